//--- design/freshness_pkg.sv
package freshness_pkg;

    localparam int BYTE_WIDTH = 8;

    // Ingredient IDs and range bounds
    localparam int ID_WIDTH = 49;
    localparam int ID_BYTES = 7;

    // Chain length, one range per stage
    localparam int RANGE_UNITS = 16;

    localparam int RESULT_WIDTH = 16;

    // Counts 0 .. ID_BYTES
    localparam int BYTE_CNT_WIDTH = $clog2(ID_BYTES + 1);

    // First byte of a record
    typedef enum logic [BYTE_WIDTH-1:0] {
        OP_RANGE = 8'h52,
        OP_ID    = 8'h49
    } opcode_t;

    typedef enum logic [1:0] {
        WAIT_OP,
        RANGE_LO,
        RANGE_HI,
        ID_VAL
    } dec_state_t;

    // sel is 1 for an ID, 0 for a range bound
    typedef struct packed {
        logic                sel;
        logic                valid;
        logic [ID_WIDTH-1:0] data;
    } id_word_t;

    // updated lands on bit 16, count is shifted out LSB first
    typedef struct packed {
        logic                    updated;
        logic [RESULT_WIDTH-1:0] count;
    } result_t;

endpackage

//--- design/tap_decoder.sv
module tap_decoder (
    input  logic                               tck,
    input  logic                               rst,
    input  logic                               tdi,
    input  logic                               ir_is_user,
    input  logic                               shift_dr,
    input  logic                               update_dr,
    output logic [freshness_pkg::BYTE_WIDTH-1:0] byte_data,
    output logic                               byte_valid
);

    import freshness_pkg::*;

    logic [BYTE_WIDTH-1:0] shift_q;
    logic                  do_shift;
    logic                  do_update;

    assign do_shift  = ir_is_user && shift_dr;
    assign do_update = ir_is_user && update_dr;

    // LSB arrives first, so new bits enter at the top
    always_ff @(posedge tck) begin
        if (do_shift) begin
            shift_q <= {tdi, shift_q[BYTE_WIDTH-1:1]};
        end
    end

    always_ff @(posedge tck) begin
        if (do_update) begin
            byte_data <= shift_q;
        end
    end

    // One-cycle strobe after update-DR
    always_ff @(posedge tck) begin
        if (rst) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= do_update;
        end
    end

    // TAP can't be in Shift-DR and Update-DR at once
    a_shift_update_exclusive: assert property (
        @(posedge tck) disable iff (rst)
        !(shift_dr && update_dr)
    );

endmodule

//--- design/input_decoder.sv
module input_decoder (
    input  logic                                 tck,
    input  logic                                 rst,
    input  logic                                 byte_valid,
    input  logic [freshness_pkg::BYTE_WIDTH-1:0] byte_data,
    output freshness_pkg::id_word_t              word
);

    import freshness_pkg::*;

    dec_state_t                state;
    opcode_t                   opcode;
    logic [BYTE_CNT_WIDTH-1:0] byte_cnt;
    logic [ID_WIDTH-1:0]       value_q;
    logic [ID_WIDTH-1:0]       value_next;
    logic                      value_done;
    logic                      in_value;

    assign opcode = opcode_t'(byte_data);

    // Big-endian, upper bits of the first byte fall off
    assign value_next = {value_q[ID_WIDTH-BYTE_WIDTH-1:0], byte_data};

    assign in_value   = (state != WAIT_OP);
    assign value_done = (byte_cnt == BYTE_CNT_WIDTH'(ID_BYTES - 1));

    always_ff @(posedge tck) begin
        if (byte_valid && in_value) begin
            value_q <= value_next;
        end
    end

    always_ff @(posedge tck) begin
        if (rst) begin
            state      <= WAIT_OP;
            byte_cnt   <= '0;
            word.valid <= 1'b0;
        end else begin
            word.valid <= 1'b0;
            if (byte_valid) begin
                case (state)
                    WAIT_OP: begin
                        // Unknown opcodes are dropped here
                        if (opcode == OP_RANGE) begin
                            state <= RANGE_LO;
                        end else if (opcode == OP_ID) begin
                            state <= ID_VAL;
                        end
                    end
                    default: begin
                        if (value_done) begin
                            word.valid <= 1'b1;
                            word.sel   <= (state == ID_VAL);
                            word.data  <= value_next;
                            byte_cnt   <= '0;
                            if (state == RANGE_LO) begin
                                state <= RANGE_HI;
                            end else begin
                                state <= WAIT_OP;
                            end
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    a_byte_cnt_bound: assert property (
        @(posedge tck) disable iff (rst)
        byte_cnt <= ID_BYTES
    );

endmodule

//--- design/range_check.sv
module range_check (
    input  logic                    tck,
    input  logic                    rst,
    input  freshness_pkg::id_word_t upstream,
    output freshness_pkg::id_word_t downstream
);

    import freshness_pkg::*;

    typedef enum logic [1:0] {
        FILL_EMPTY,
        FILL_LOW,
        FILL_FULL
    } fill_t;

    fill_t               fill;
    logic [ID_WIDTH-1:0] lo_q;
    logic [ID_WIDTH-1:0] hi_q;
    logic                is_range;
    logic                is_id;
    logic                capture;
    logic                in_range;
    logic                absorb;

    assign is_range = upstream.valid && !upstream.sel;
    assign is_id    = upstream.valid && upstream.sel;
    assign capture  = is_range && (fill != FILL_FULL);

    // Inclusive on both ends
    assign in_range = (upstream.data >= lo_q) && (upstream.data <= hi_q);
    assign absorb   = is_id && (fill == FILL_FULL) && in_range;

    always_ff @(posedge tck) begin
        if (capture && fill == FILL_EMPTY) begin
            lo_q <= upstream.data;
        end
        if (capture && fill == FILL_LOW) begin
            hi_q <= upstream.data;
        end
    end

    always_ff @(posedge tck) begin
        if (rst) begin
            fill <= FILL_EMPTY;
        end else if (capture) begin
            fill <= (fill == FILL_EMPTY) ? FILL_LOW : FILL_FULL;
        end
    end

    always_ff @(posedge tck) begin
        if (rst) begin
            downstream.valid <= 1'b0;
        end else begin
            downstream.valid <= upstream.valid && !capture && !absorb;
            downstream.sel   <= upstream.sel;
            downstream.data  <= upstream.data;
        end
    end

    a_no_captured_out: assert property (
        @(posedge tck) disable iff (rst)
        capture |=> !downstream.valid
    );

endmodule

//--- design/tap_encoder.sv
module tap_encoder (
    input  logic                   tck,
    input  logic                   rst,
    input  logic                   ir_is_user,
    input  logic                   capture_dr,
    input  logic                   shift_dr,
    input  freshness_pkg::result_t result,
    output logic                   tdo,
    output logic                   captured
);

    import freshness_pkg::*;

    localparam int SHIFT_BITS = $bits(result_t);

    logic [SHIFT_BITS-1:0] shift_q;
    logic                  do_capture;
    logic                  do_shift;

    assign do_capture = ir_is_user && capture_dr;
    assign do_shift   = ir_is_user && shift_dr;

    // Tells user_logic to clear its updated flag
    assign captured = do_capture;

    // Count goes out LSB first, updated flag last
    always_ff @(posedge tck) begin
        if (rst) begin
            shift_q <= '0;
        end else if (do_capture) begin
            shift_q <= result;
        end else if (do_shift) begin
            shift_q <= {1'b0, shift_q[SHIFT_BITS-1:1]};
        end
    end

    assign tdo = shift_q[0];

    // Capture-DR and Shift-DR are distinct TAP states
    a_capture_shift_exclusive: assert property (
        @(posedge tck) disable iff (rst)
        !(capture_dr && shift_dr)
    );

endmodule

//--- design/user_logic.sv
module user_logic (
    input  logic tck,
    input  logic rst,
    input  logic tdi,
    input  logic ir_is_user,
    input  logic capture_dr,
    input  logic shift_dr,
    input  logic update_dr,
    output logic tdo
);

    import freshness_pkg::*;

    logic [BYTE_WIDTH-1:0]   byte_data;
    logic                    byte_valid;
    id_word_t                chain [0:RANGE_UNITS];
    logic [RESULT_WIDTH-1:0] total_q;
    logic [RESULT_WIDTH-1:0] spoiled_q;
    logic                    updated_q;
    logic                    total_inc;
    logic                    spoiled_inc;
    logic                    captured;
    result_t                 result;

    tap_decoder tap_decoder_i (
        .tck        (tck),
        .rst        (rst),
        .tdi        (tdi),
        .ir_is_user (ir_is_user),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    input_decoder input_decoder_i (
        .tck        (tck),
        .rst        (rst),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .word       (chain[0])
    );

    for (genvar i = 0; i < RANGE_UNITS; i++) begin : range_check_gen
        range_check range_check_i (
            .tck        (tck),
            .rst        (rst),
            .upstream   (chain[i]),
            .downstream (chain[i+1])
        );
    end

    // IDs entering the chain vs. IDs that fell out the far end
    assign total_inc   = chain[0].valid && chain[0].sel;
    assign spoiled_inc = chain[RANGE_UNITS].valid && chain[RANGE_UNITS].sel;

    always_ff @(posedge tck) begin
        if (rst) begin
            total_q   <= '0;
            spoiled_q <= '0;
            updated_q <= 1'b0;
        end else begin
            if (total_inc) begin
                total_q <= total_q + 1'b1;
            end
            if (spoiled_inc) begin
                spoiled_q <= spoiled_q + 1'b1;
            end
            // a new increment wins over a read in the same cycle
            if (total_inc || spoiled_inc) begin
                updated_q <= 1'b1;
            end else if (captured) begin
                updated_q <= 1'b0;
            end
        end
    end

    assign result.count   = total_q - spoiled_q;
    assign result.updated = updated_q;

    tap_encoder tap_encoder_i (
        .tck        (tck),
        .rst        (rst),
        .ir_is_user (ir_is_user),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .result     (result),
        .tdo        (tdo),
        .captured   (captured)
    );

endmodule

//--- verification/tb_clock.sv
module tb_clock (
    output logic tck,
    output logic rst
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 16;

    initial begin
        tck = 1'b0;
        forever begin
            #HALF_PERIOD tck = ~tck;
        end
    end

    // Stands in for test-logic-reset
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge tck);
        rst <= 1'b0;
    end

endmodule

//--- verification/tb_user_logic.sv
module tb_user_logic;

    import freshness_pkg::*;

    localparam string GOLDEN_FILE   = "verification/freshness_golden.txt";
    localparam int    RESET_TIMEOUT = 100;
    localparam int    MAX_LINES     = 500;
    localparam int    SETTLE_CYCLES = 40;
    localparam int    MAX_GAP       = 4;

    logic tck;
    logic rst;
    logic tdi;
    logic ir_is_user;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic tdo;
    int   error_count;
    int   test_errors;
    int   tests_run;
    int   tests_failed;

    tb_clock tb_clock_i (
        .tck (tck),
        .rst (rst)
    );

    user_logic user_logic_i (
        .tck        (tck),
        .rst        (rst),
        .tdi        (tdi),
        .ir_is_user (ir_is_user),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .tdo        (tdo)
    );

    task automatic count_error;
        error_count++;
        test_errors++;
    endtask

    // Eight Shift-DR cycles LSB first, then one Update-DR
    task automatic send_byte(input logic [BYTE_WIDTH-1:0] value);
        int gap;
        int i;
        gap = $urandom % MAX_GAP;
        repeat (gap) @(posedge tck);
        for (i = 0; i < BYTE_WIDTH; i++) begin
            @(posedge tck);
            shift_dr <= 1'b1;
            tdi      <= value[i];
        end
        @(posedge tck);
        shift_dr  <= 1'b0;
        update_dr <= 1'b1;
        @(posedge tck);
        update_dr <= 1'b0;
    endtask

    // Big-endian, top byte carries the ID's upper bit
    task automatic send_value(input logic [ID_WIDTH-1:0] value);
        logic [ID_BYTES*BYTE_WIDTH-1:0] padded;
        int k;
        padded = {{(ID_BYTES * BYTE_WIDTH - ID_WIDTH){1'b0}}, value};
        for (k = ID_BYTES - 1; k >= 0; k--) begin
            send_byte(padded[k*BYTE_WIDTH +: BYTE_WIDTH]);
        end
    endtask

    task automatic read_result(output result_t got);
        logic [$bits(result_t)-1:0] raw;
        int i;
        repeat (SETTLE_CYCLES) @(posedge tck);
        capture_dr <= 1'b1;
        @(posedge tck);
        capture_dr <= 1'b0;
        shift_dr   <= 1'b1;
        for (i = 0; i < $bits(result_t); i++) begin
            @(negedge tck);
            raw[i] = tdo;
            @(posedge tck);
        end
        shift_dr <= 1'b0;
        got = raw;
    endtask

    task automatic check_read(input logic [RESULT_WIDTH-1:0] exp_count, input logic exp_flag);
        result_t got;
        read_result(got);
        if (got.count !== exp_count) begin
            $display("[ERROR] %0t count: expected %0d, got %0d", $time, exp_count, got.count);
            count_error();
        end
        if (got.updated !== exp_flag) begin
            $display("[ERROR] %0t updated: expected %0b, got %0b", $time, exp_flag,
                     got.updated);
            count_error();
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    function automatic string trim_line(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == "\n" || t.getc(t.len() - 1) == "\r"
                               || t.getc(t.len() - 1) == " ")) begin
            t = t.substr(0, t.len() - 2);
        end
        return t;
    endfunction

    task automatic run_command(input string line);
        logic [7:0]  cmd;
        logic [63:0] arg_a;
        logic [63:0] arg_b;
        int          n;
        cmd = line.getc(0);
        n   = $sscanf(line.substr(1, line.len() - 1), "%h %h", arg_a, arg_b);
        case (cmd)
            "R": begin
                if (n == 2) begin
                    send_byte(OP_RANGE);
                    send_value(arg_a[ID_WIDTH-1:0]);
                    send_value(arg_b[ID_WIDTH-1:0]);
                end else begin
                    $display("Golden line has a bad range: %s", line);
                    count_error();
                end
            end
            "I": begin
                send_byte(OP_ID);
                send_value(arg_a[ID_WIDTH-1:0]);
            end
            "B": send_byte(arg_a[BYTE_WIDTH-1:0]);
            "C": begin
                if (n == 2) begin
                    check_read(arg_a[RESULT_WIDTH-1:0], arg_b[0]);
                end else begin
                    $display("Golden line has a bad read check: %s", line);
                    count_error();
                end
            end
            "T": end_test(line.substr(2, line.len() - 1));
            "#": ;
            default: begin
                $display("Golden line not understood: %s", line);
                count_error();
            end
        endcase
    endtask

    task automatic run_golden;
        int    fd;
        int    lines;
        int    got;
        string line;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open %s for reading", GOLDEN_FILE);
            count_error();
        end else begin
            lines = 0;
            while (!$feof(fd) && lines < MAX_LINES) begin
                got = $fgets(line, fd);
                lines++;
                line = trim_line(line);
                if (got != 0 && line.len() > 0) begin
                    run_command(line);
                end
            end
            if (!$feof(fd)) begin
                $display("Golden file has more than %0d lines", MAX_LINES);
                count_error();
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_reset(output bit released);
        int cycles;
        released = 1'b0;
        cycles   = 0;
        while (!released && cycles < RESET_TIMEOUT) begin
            @(posedge tck);
            cycles++;
            if (!rst) begin
                released = 1'b1;
            end
        end
    endtask

    initial begin
        bit reset_done;
        void'($urandom(32'hb056));
        error_count  = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        tdi        <= 1'b0;
        ir_is_user <= 1'b1;
        capture_dr <= 1'b0;
        shift_dr   <= 1'b0;
        update_dr  <= 1'b0;
        wait_reset(reset_done);
        if (!reset_done) begin
            $display("Timeout: reset was still high after %0d cycles", RESET_TIMEOUT);
            error_count++;
        end else begin
            // Encoder register is cleared by reset
            if (tdo !== 1'b0) begin
                $display("[ERROR] %0t tdo: expected 0, got %b", $time, tdo);
                count_error();
            end
            run_golden();
        end
        if (tests_run == 0) begin
            $display("No test was completed from the golden file");
            error_count++;
        end
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verification/freshness_golden.txt
# Columns: command letter, then hex arguments
# R lo hi | I id | B byte | C count updated | T test_name
C 0 0
T reset_state
I 100
I 200
I 300
C 0 1
C 0 0
T no_ranges
R 1000 1fff
R 5000 5010
R 1000000000000 1000000000010
I 1000
I 1fff
I 1800
I fff
I 2000
I 5000
I 5011
I 1000000000010
I 1000000000011
I ffffffffffff
C 5 1
T bounds
R 1800 2800
I 1900
I 2500
I 2801
C 7 1
T overlap
R 10000 1000f
R 20000 2000f
R 30000 3000f
R 40000 4000f
R 50000 5000f
R 60000 6000f
R 70000 7000f
R 80000 8000f
R 90000 9000f
R a0000 a000f
R b0000 b000f
R c0000 c000f
R d0000 d00ff
R e0000 e00ff
I c0005
I 10000
I d0010
I e0000
C 9 1
T capacity
B 0
B ff
B a5
C 9 0
I 1000
B 37
C a 1
T unknown_opcodes

//--- flist.f
design/freshness_pkg.sv
design/tap_decoder.sv
design/input_decoder.sv
design/range_check.sv
design/tap_encoder.sv
design/user_logic.sv
verification/tb_clock.sv
verification/tb_user_logic.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_user_logic -f flist.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qx "Done: no errors" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
